// File: compile.f
rtl/mipsPkg.sv
rtl/inputSync.sv
rtl/stepDivider.sv
rtl/programRom.sv
rtl/dataRam.sv
rtl/registerFile.sv
rtl/mipsCore.sv
rtl/mipsTop.sv
verif/mipsTop_asserts.sv
verif/mipsTopTb.sv

// File: Makefile
# Verilator build and run of the MIPS subsystem testbench
TOP := mipsTopTb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing --assert -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: verif/mipsTopTb.sv
/*
 * Directed testbench for the MIPS subsystem:
 * clock and reset, debug register reads and compare task,
 * idle, full program and divider pacing tests
 */
`default_nettype none

module mipsTopTb;
    import mipsPkg::*;

    // r8 counts down from loopStart while r2 sums it
    localparam int loopStart   = 10;
    localparam int resetCycles = 8;
    localparam int syncDelay   = 2;
    localparam int runTimeout  = 500;

    logic    clk;
    logic    reset;
    divide_t clkDivide;
    logic    clkEnable;
    regIdx_t regAddr;
    word_t   regData;

    mipsTop mipsTop_i (
        .clk       (clk),
        .reset     (reset),
        .clkDivide (clkDivide),
        .clkEnable (clkEnable),
        .regAddr   (regAddr),
        .regData   (regData)
    );

    always #5 clk = ~clk;

    // sum the addu loop builds from loopStart down to 1
    function automatic word_t loopSum(input int count);
        word_t total;
        total = '0;
        for (int i = count; i > 0; i--)
            total = total + word_t'(i);
        return total;
    endfunction

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(input string name, input word_t actual, input word_t expected);
        if (actual !== expected)
            stopWithFailure($sformatf("** Error: %s: got %h, expected %h",
                                      name, actual, expected));
    endtask

    task automatic waitCycles(input int count);
        repeat (count) @(negedge clk);
    endtask

    // two sync flops on regAddr plus one cycle of margin
    task automatic readReg(input regIdx_t idx, input word_t expected);
        regAddr = idx;
        waitCycles(3);
        checkWord($sformatf("regData[r%0d]", idx), regData, expected);
    endtask

    task automatic resetDut(input divide_t divide, input logic enable);
        @(negedge clk);
        reset     = 1'b1;
        clkDivide = divide;
        clkEnable = enable;
        regAddr   = '0;
        waitCycles(resetCycles);
        reset = 1'b0;
    endtask

    task automatic checkProgramRegsZero();
        readReg(5'd0, '0);
        readReg(5'd2, '0);
        readReg(5'd3, '0);
        readReg(5'd4, '0);
        readReg(5'd8, '0);
    endtask

    // nothing may execute while enable stays low
    task automatic idleTest();
        resetDut(4'd0, 1'b0);
        checkProgramRegsZero();
        waitCycles(200);
        checkProgramRegsZero();
    endtask

    // step every cycle and poll r4 until the program has finished
    task automatic runProgramTest();
        int    cycles;
        word_t sum;
        sum       = loopSum(loopStart);
        clkDivide = 4'd0;
        clkEnable = 1'b1;
        regAddr   = 5'd4;
        cycles    = 0;
        while (regData !== sum + 32'd1 && cycles < runTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (regData !== sum + 32'd1)
            stopWithFailure("timeout: r4 never reached its final value");
        readReg(5'd2, sum);
        // lw reads back what sw stored from r2
        readReg(5'd3, sum);
        readReg(5'd8, '0);
        readReg(5'd0, '0);
    endtask

    // divide 3 gives one step per 8 cycles with each commit one edge after its strobe
    task automatic pacingTest();
        int period;
        period = 1 << 3;
        resetDut(4'd3, 1'b1);
        // first strobe follows edge 10 and addiu r8 commits at edge 11
        waitCycles(syncDelay + period);
        readReg(5'd8, word_t'(loopStart));
        // r2 untouched until the first addu at edge 27
        readReg(5'd2, '0);
        readReg(5'd0, '0);
        // first addu has now added r8 into r2
        waitCycles(11);
        readReg(5'd2, word_t'(loopStart));
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        clkDivide = '0;
        clkEnable = 1'b0;
        regAddr   = '0;
        idleTest();
        runProgramTest();
        pacingTest();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/mipsTop_asserts.sv
/*
 * Concurrent checks on the data memory handshake and the
 * step strobe, bound into the subsystem top level
 */
`default_nettype none

module mipsTopAsserts (
    input wire                   clk,
    input wire                   reset,
    input wire                   valid,
    input wire mipsPkg::memReq_t req,
    input wire                   ready,
    input wire                   step,
    input wire                   enable,
    input wire mipsPkg::divide_t divide
);
    // request held stable until the RAM answers
    validHeld: assert property (@(posedge clk) disable iff (reset)
        valid && !ready |=> valid && $stable(req))
        else $error("memory request dropped or changed before ready");

    readyFollows: assert property (@(posedge clk) disable iff (reset)
        valid && !ready |=> ready)
        else $error("ready missing one cycle after valid");

    readyHasRequest: assert property (@(posedge clk) disable iff (reset)
        ready |-> $past(valid && !ready))
        else $error("ready without a pending request");

    validDrops: assert property (@(posedge clk) disable iff (reset)
        ready |=> !valid)
        else $error("valid still high after ready");

    // divide 0 strobes every cycle by design
    stepSingle: assert property (@(posedge clk) disable iff (reset)
        step && divide != '0 |=> !step)
        else $error("step lasted more than one cycle");

    stepIdle: assert property (@(posedge clk) disable iff (reset)
        !enable && $past(!enable) && $past(!enable, 2) |-> !step)
        else $error("step while enable was low");

endmodule

bind mipsTop mipsTopAsserts mipsTopAsserts_i (
    .clk    (clk),
    .reset  (reset),
    .valid  (dmValid),
    .req    (dmReq),
    .ready  (dmReady),
    .step   (step),
    .enable (enable),
    .divide (divide)
);

`default_nettype wire

// File: rtl/mipsTop.sv
/*
 * Subsystem top level: input synchronizers, step divider,
 * boot ROM, data RAM and the core
 */
`default_nettype none

module mipsTop (
    input  wire                   clk,
    input  wire                   reset,
    input  wire mipsPkg::divide_t clkDivide,
    input  wire                   clkEnable,
    input  wire mipsPkg::regIdx_t regAddr,
    output mipsPkg::word_t        regData
);
    import mipsPkg::*;

    divide_t            divide;
    logic               enable;
    regIdx_t            debugAddr;
    logic               step;
    logic [pcWidth-1:0] imAddr;
    word_t              imData;
    logic               dmValid;
    memReq_t            dmReq;
    logic               dmReady;
    word_t              dmRData;

    // slow external levels
    inputSync #(.payload_t(divide_t)) divideSync_i (
        .clk (clk), .reset (reset), .d (clkDivide), .q (divide)
    );
    inputSync #(.payload_t(logic)) enableSync_i (
        .clk (clk), .reset (reset), .d (clkEnable), .q (enable)
    );
    inputSync #(.payload_t(regIdx_t)) regAddrSync_i (
        .clk (clk), .reset (reset), .d (regAddr), .q (debugAddr)
    );

    stepDivider stepDivider_i (
        .clk    (clk),
        .reset  (reset),
        .enable (enable),
        .divide (divide),
        .step   (step)
    );

    programRom programRom_i (
        .addr (imAddr),
        .data (imData)
    );

    dataRam dataRam_i (
        .clk   (clk),
        .reset (reset),
        .valid (dmValid),
        .req   (dmReq),
        .ready (dmReady),
        .rdata (dmRData)
    );

    mipsCore mipsCore_i (
        .clk     (clk),
        .reset   (reset),
        .step    (step),
        .imAddr  (imAddr),
        .imData  (imData),
        .dmValid (dmValid),
        .dmReq   (dmReq),
        .dmReady (dmReady),
        .dmRData (dmRData),
        .regAddr (debugAddr),
        .regData (regData)
    );

endmodule

`default_nettype wire

// File: rtl/mipsCore.sv
/*
 * Single-cycle MIPS core: program counter, decoder, ALU,
 * beq/bne branch logic and the data memory wait state
 */
`default_nettype none

module mipsCore (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        step,
    output logic [mipsPkg::pcWidth-1:0] imAddr,
    input  wire mipsPkg::word_t        imData,
    output logic                       dmValid,
    output mipsPkg::memReq_t           dmReq,
    input  wire                        dmReady,
    input  wire mipsPkg::word_t        dmRData,
    input  wire mipsPkg::regIdx_t      regAddr,
    output mipsPkg::word_t             regData
);
    import mipsPkg::*;

    typedef enum logic {
        run,
        memWait
    } state_t;

    state_t             state;
    logic [pcWidth-1:0] pc;
    logic [pcWidth-1:0] pcNext;
    instr_t             instr;
    word_t              immExt;
    word_t              dataA;
    word_t              dataB;
    word_t              aluResult;
    logic               isAddiu;
    logic               isAddu;
    logic               isMem;
    logic               taken;
    logic               writeEn;
    regIdx_t            writeAddr;
    word_t              writeData;

    assign imAddr = pc;
    assign instr  = instr_t'(imData);
    // immediate occupies the low half word
    assign immExt = {{16{imData[15]}}, imData[15:0]};

    // decode
    assign isAddiu = (instr.op == opAddiu);
    assign isAddu  = (instr.op == opSpecial) && (instr.funct == fnAddu);
    assign isMem   = (instr.op == opLw) || (instr.op == opSw);

    // ALU, also the memory address for lw/sw
    assign aluResult = isAddu ? dataA + dataB : dataA + immExt;

    // branches use PC+1+offset in words
    assign taken  = ((instr.op == opBeq) && (dataA == dataB))
                 || ((instr.op == opBne) && (dataA != dataB));
    assign pcNext = taken ? pc + pcWidth'(1) + immExt[pcWidth-1:0] : pc + pcWidth'(1);

    // register write, either on a step or on the lw answer
    always_comb begin
        writeEn   = 1'b0;
        writeAddr = instr.rt;
        writeData = aluResult;
        if (state == memWait) begin
            writeEn   = dmReady && (instr.op == opLw);
            writeData = dmRData;
        end else if (step) begin
            writeEn = isAddiu || isAddu;
            if (isAddu)
                writeAddr = instr.rd;
        end
    end

    registerFile registerFile_i (
        .clk       (clk),
        .reset     (reset),
        .readA     (instr.rs),
        .readB     (instr.rt),
        .dataA     (dataA),
        .dataB     (dataB),
        .debugAddr (regAddr),
        .debugData (regData),
        .writeEn   (writeEn),
        .writeAddr (writeAddr),
        .writeData (writeData)
    );

    // pc and memory wait controller
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= run;
            pc      <= '0;
            dmValid <= 1'b0;
        end else begin
            case (state)
                run: begin
                    if (step) begin
                        if (isMem) begin
                            dmValid <= 1'b1;
                            state   <= memWait;
                        end else begin
                            pc <= pcNext;
                        end
                    end
                end
                memWait: begin
                    // steps arriving here are dropped
                    if (dmReady) begin
                        dmValid <= 1'b0;
                        pc      <= pc + pcWidth'(1);
                        state   <= run;
                    end
                end
                default: state <= run;
            endcase
        end
    end

    // request payload, stable for the whole wait
    always_ff @(posedge clk) begin
        if (state == run && step && isMem) begin
            dmReq.addr  <= aluResult;
            dmReq.we    <= (instr.op == opSw);
            dmReq.wdata <= dataB;
        end
    end

endmodule

`default_nettype wire

// File: rtl/registerFile.sv
/*
 * General register file, 32 x 32 bits:
 * two read ports, a debug read port and one write port,
 * register zero fixed at zero
 */
`default_nettype none

module registerFile (
    input  wire                   clk,
    input  wire                   reset,
    input  wire mipsPkg::regIdx_t readA,
    input  wire mipsPkg::regIdx_t readB,
    output mipsPkg::word_t        dataA,
    output mipsPkg::word_t        dataB,
    input  wire mipsPkg::regIdx_t debugAddr,
    output mipsPkg::word_t        debugData,
    input  wire                   writeEn,
    input  wire mipsPkg::regIdx_t writeAddr,
    input  wire mipsPkg::word_t   writeData
);
    import mipsPkg::*;

    word_t regs [2**$bits(regIdx_t)];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**$bits(regIdx_t); i++)
                regs[i] <= '0;
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // reads are asynchronous, r0 forced to zero
    assign dataA     = (readA == '0) ? '0 : regs[readA];
    assign dataB     = (readB == '0) ? '0 : regs[readB];
    assign debugData = (debugAddr == '0) ? '0 : regs[debugAddr];

endmodule

`default_nettype wire

// File: rtl/dataRam.sv
/*
 * Word-addressed scratchpad RAM with a valid/ready handshake,
 * answering one cycle after the request is sampled
 */
`default_nettype none

module dataRam (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   valid,
    input  wire mipsPkg::memReq_t req,
    output logic                  ready,
    output mipsPkg::word_t        rdata
);
    import mipsPkg::*;

    word_t                   mem [ramDepth];
    logic [ramAddrWidth-1:0] index;
    logic                    accept;

    // byte address to word index
    assign index  = req.addr[ramAddrWidth+1:2];
    // new request, not the held one during ready
    assign accept = valid && !ready;

    always_ff @(posedge clk) begin
        if (reset)
            ready <= 1'b0;
        else
            ready <= accept;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (req.we)
                mem[index] <= req.wdata;
            rdata <= mem[index];
        end
    end

endmodule

`default_nettype wire

// File: rtl/programRom.sv
/*
 * Boot ROM with the fixed demonstration program:
 * sums 10 down to 1, stores and reloads the sum, then halts
 */
`default_nettype none

module programRom (
    input  wire [mipsPkg::pcWidth-1:0] addr,
    output mipsPkg::word_t             data
);
    import mipsPkg::*;

    function automatic word_t iType(logic [5:0] op, regIdx_t rs, regIdx_t rt,
                                    logic [15:0] imm);
        iType = {op, rs, rt, imm};
    endfunction

    function automatic word_t rType(regIdx_t rs, regIdx_t rt, regIdx_t rd,
                                    logic [5:0] funct);
        instr_t ins;
        ins = '{op: opSpecial, rs: rs, rt: rt, rd: rd, shamt: 5'd0, funct: funct};
        rType = word_t'(ins);
    endfunction

    always_comb begin
        case (addr)
            5'd0:    data = iType(opAddiu, 5'd0, 5'd8, 16'd10);
            5'd1:    data = iType(opAddiu, 5'd0, 5'd2, 16'd0);
            5'd2:    data = rType(5'd2, 5'd8, 5'd2, fnAddu);
            5'd3:    data = iType(opAddiu, 5'd8, 5'd8, 16'hffff);
            // back to index 2
            5'd4:    data = iType(opBne, 5'd8, 5'd0, 16'hfffd);
            5'd5:    data = iType(opSw, 5'd0, 5'd2, 16'd16);
            5'd6:    data = iType(opLw, 5'd0, 5'd3, 16'd16);
            5'd7:    data = iType(opAddiu, 5'd3, 5'd4, 16'd1);
            // spin in place
            5'd8:    data = iType(opBeq, 5'd0, 5'd0, 16'hffff);
            default: data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/stepDivider.sv
/*
 * Step divider: free-running counter with enable that
 * strobes one core step every 2^divide cycles
 */
`default_nettype none

module stepDivider (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  enable,
    input  wire mipsPkg::divide_t divide,
    output logic                 step
);
    logic [15:0] count;
    logic [15:0] countNext;
    logic [15:0] mask;

    assign countNext = count + 16'd1;
    // bits below the divide setting, empty for divide 0
    assign mask = (16'd1 << divide) - 16'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            step  <= 1'b0;
        end else begin
            step <= enable && ((countNext & mask) == 16'd0);
            if (enable)
                count <= countNext;
        end
    end

endmodule

`default_nettype wire

// File: rtl/inputSync.sv
/*
 * Two-flop synchronizer for slow asynchronous levels
 */
`default_nettype none

module inputSync #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      reset,
    input  wire      payload_t d,
    output payload_t q
);
    payload_t meta;

    always_ff @(posedge clk) begin
        if (reset) begin
            meta <= '0;
            q    <= '0;
        end else begin
            meta <= d;
            q    <= meta;
        end
    end

endmodule

`default_nettype wire

// File: rtl/mipsPkg.sv
/*
 * Shared definitions for the small MIPS subsystem:
 * data and index types, memory request struct, instruction
 * fields, memory sizes and the opcode and funct constants.
 */
`default_nettype none

package mipsPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;
    typedef logic [3:0]  divide_t;

    // data memory request, held stable while valid is high
    typedef struct packed {
        word_t addr;
        logic  we;
        word_t wdata;
    } memReq_t;

    // R-type view, immediate is {rd, shamt, funct} for I-type
    typedef struct packed {
        logic [5:0] op;
        regIdx_t    rs;
        regIdx_t    rt;
        regIdx_t    rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_t;

    localparam int romDepth     = 32;
    localparam int ramDepth     = 64;
    localparam int pcWidth      = $clog2(romDepth);
    localparam int ramAddrWidth = $clog2(ramDepth);

    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opBeq     = 6'b000100;
    localparam logic [5:0] opBne     = 6'b000101;
    localparam logic [5:0] opAddiu   = 6'b001001;
    localparam logic [5:0] opLw      = 6'b100011;
    localparam logic [5:0] opSw      = 6'b101011;
    localparam logic [5:0] fnAddu    = 6'b100001;

endpackage

`default_nettype wire
